/* source/power_meter_cfg.svh */
// Build-time widths and block length of the power meter; include before using the types.
`ifndef POWER_METER_CFG_SVH
`define POWER_METER_CFG_SVH

// Width of each signed I and Q part.
`define SAMPLE_WIDTH 12

// Room for I*I + Q*Q, full-scale negative inputs included.
`define POWER_WIDTH (2 * `SAMPLE_WIDTH)

// Samples per block as a power of two; 2 gives blocks of 4.
`define BLOCK_LOG2 2

// A block sum grows by one bit per doubling of the block.
`define SUM_WIDTH (`POWER_WIDTH + `BLOCK_LOG2)

`endif

/* source/power_meter_pkg.sv */
// Payload types of the power meter streams, imported by every stage and the top level.
`include "power_meter_cfg.svh"

package power_meter_pkg;

	// One complex baseband sample.
	typedef struct packed {
		logic signed [`SAMPLE_WIDTH-1:0] i; // In-phase part, upper bits.
		logic signed [`SAMPLE_WIDTH-1:0] q; // Quadrature part.
	} iq_sample_t;

	// Instantaneous power of one sample.
	typedef struct packed {
		logic [`POWER_WIDTH-1:0] value; // Always non-negative.
	} power_t;

	// Power summed over one block.
	typedef struct packed {
		logic [`SUM_WIDTH-1:0] value; // Cannot wrap for any input.
	} block_sum_t;

endpackage

/* source/axis_register.sv */
// Fully registered valid/ready slice with a one-entry skid buffer, for any packed payload type.
`timescale 1ns/1ps

module axis_register #(
	parameter type payload_t = logic [7:0] // Any packed struct or vector.
) (
	input  logic     clock,
	input  logic     resetn,
	input  payload_t idata,
	input  logic     ivalid,
	output logic     iready, // Registered, high while the skid entry is free.
	output payload_t odata,
	output logic     ovalid,
	input  logic     oready
);

	// Flag encoding of the two storage places:
	// iready  & !ovalid  nothing held.
	// iready  &  ovalid  output register full, skid free.
	// !iready &  ovalid  both full, input blocked.
	// !iready & !ovalid  never reached.

	payload_t skid; // Item caught while the output was stalled.
	logic     hold; // Output item stays for another cycle.

	assign hold = ovalid && !oready;

	// Flags only; the data paths below run without reset.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			ovalid <= 1'b0;
			iready <= 1'b1; // Empty slice accepts at once.
		end
		else
		begin
			// Output stays full if stalled, if the skid drains into it, or on a new item.
			ovalid <= hold || !iready || ivalid;
			// Blocked only when the output is stuck and a second item is held or arriving.
			iready <= !ovalid || oready || (iready && !ivalid);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			if (iready)
				odata <= idata; // Pass straight through.
			else
				odata <= skid; // Drain the skid entry first.
		end
		if (iready)
			skid <= idata; // Only counts when the output is stalled.
	end

endmodule

/* source/power_square.sv */
// Pipeline stage turning each I/Q sample into its power I*I + Q*Q, one cycle of latency.
`timescale 1ns/1ps

module power_square (
	input  logic                       clock,
	input  logic                       resetn,
	input  power_meter_pkg::iq_sample_t in_data,
	input  logic                       in_valid,
	output logic                       in_ready,
	output power_meter_pkg::power_t    out_data,
	output logic                       out_valid,
	input  logic                       out_ready
);

	import power_meter_pkg::*;

	localparam int POWER_WIDTH = $bits(power_t);

	logic signed [POWER_WIDTH-1:0] i_sq;   // I squared, sign-extended product.
	logic signed [POWER_WIDTH-1:0] q_sq;   // Q squared.
	logic        [POWER_WIDTH-1:0] sum_sq; // Their sum, non-negative.
	logic                          accept; // Sample taken this edge.

	// Full-width signed products so -2048 squares without overflow.
	assign i_sq = $signed(in_data.i) * $signed(in_data.i);
	assign q_sq = $signed(in_data.q) * $signed(in_data.q);

	// Each square is at most 2^(2W-2), so the sum fits unsigned in 2W bits.
	assign sum_sq = $unsigned(i_sq) + $unsigned(q_sq);

	// Room when the result register is empty or drains on this edge.
	assign in_ready = !out_valid || out_ready; // Combinational from downstream.
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1; // New result replaces or fills the register.
		else if (out_ready)
			out_valid <= 1'b0; // Result left, nothing behind it.
	end

	// Result register carries no reset.
	always_ff @(posedge clock)
	begin
		if (accept)
			out_data.value <= sum_sq;
	end

endmodule

/* source/block_accumulate.sv */
// Pipeline stage summing each block of powers into one block-sum word on its output stream.
`timescale 1ns/1ps

module block_accumulate (
	input  logic                        clock,
	input  logic                        resetn,
	input  power_meter_pkg::power_t     in_data,
	input  logic                        in_valid,
	output logic                        in_ready,
	output power_meter_pkg::block_sum_t out_data,
	output logic                        out_valid,
	input  logic                        out_ready
);

	import power_meter_pkg::*;

	localparam int SUM_WIDTH  = $bits(block_sum_t);
	localparam int BLOCK_LOG2 = SUM_WIDTH - $bits(power_t); // Growth bits equal block log2.

	logic [BLOCK_LOG2-1:0] count;    // Position of the next power within the block.
	logic [SUM_WIDTH-1:0]  acc;      // Running sum of the current block.
	logic [SUM_WIDTH-1:0]  base;     // What the next power is added to.
	logic [SUM_WIDTH-1:0]  in_wide;  // Incoming power, zero-extended.
	logic                  done;     // acc holds a finished block awaiting output.
	logic                  out_free; // Output register empty or draining now.
	logic                  accept;   // Power taken this edge.
	logic                  last;     // Next power closes the block.

	assign out_free = !out_valid || out_ready;
	assign in_ready = out_free; // Waits only while the output is still full.
	assign accept   = in_valid && in_ready;
	assign last     = &count;
	assign in_wide  = {{BLOCK_LOG2{1'b0}}, in_data.value};

	// A finished block leaves acc on this edge, so a new block starts from zero.
	assign base = done ? '0 : acc;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			count     <= '0;
			acc       <= '0;
			done      <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (accept)
			begin
				count <= count + 1'b1; // Wraps to zero after the last power.
				acc   <= base + in_wide;
			end
			else if (done && out_free)
				acc <= '0; // Block moved out, idle restart.

			// Finished sum waits one cycle in acc, then moves to the output.
			if (accept && last)
				done <= 1'b1;
			else if (out_free)
				done <= 1'b0;

			if (done && out_free)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	// Output word itself carries no reset.
	always_ff @(posedge clock)
	begin
		if (done && out_free)
			out_data.value <= acc;
	end

endmodule

/* source/power_meter.sv */
// Top level of the streaming power meter: I/Q samples in, one power sum per block out.
`timescale 1ns/1ps

module power_meter (
	input  logic                        clock,
	input  logic                        resetn,
	input  power_meter_pkg::iq_sample_t in_data,
	input  logic                        in_valid,
	output logic                        in_ready,
	output power_meter_pkg::block_sum_t out_data,
	output logic                        out_valid,
	input  logic                        out_ready
);

	import power_meter_pkg::*;

	iq_sample_t sq_data;  // Slice to squarer.
	logic       sq_valid;
	logic       sq_ready;
	power_t     pw_data;  // Squarer to power slice.
	logic       pw_valid;
	logic       pw_ready;
	power_t     acc_data; // Power slice to accumulator.
	logic       acc_valid;
	logic       acc_ready;

	// Registers the input ready so the squarer's ready path stays inside.
	axis_register #(
		.payload_t(iq_sample_t)
	) slice_in (
		.clock (clock),
		.resetn(resetn),
		.idata (in_data),
		.ivalid(in_valid),
		.iready(in_ready),
		.odata (sq_data),
		.ovalid(sq_valid),
		.oready(sq_ready)
	);

	power_square power_square_inst (
		.clock    (clock),
		.resetn   (resetn),
		.in_data  (sq_data),
		.in_valid (sq_valid),
		.in_ready (sq_ready),
		.out_data (pw_data),
		.out_valid(pw_valid),
		.out_ready(pw_ready)
	);

	// Breaks the ready chain between squarer and accumulator.
	axis_register #(
		.payload_t(power_t)
	) slice_power (
		.clock (clock),
		.resetn(resetn),
		.idata (pw_data),
		.ivalid(pw_valid),
		.iready(pw_ready),
		.odata (acc_data),
		.ovalid(acc_valid),
		.oready(acc_ready)
	);

	block_accumulate block_accumulate_inst (
		.clock    (clock),
		.resetn   (resetn),
		.in_data  (acc_data),
		.in_valid (acc_valid),
		.in_ready (acc_ready),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

/* verification/power_meter_checker.sv */
// Watches the power meter streams, compares block sums with the test file and reports per test.
`timescale 1ns/1ps
`include "power_meter_cfg.svh"

module power_meter_checker (
	input  logic                        clock,
	input  logic                        resetn,
	input  logic                        in_valid,
	input  logic                        in_ready,
	input  power_meter_pkg::block_sum_t out_data,
	input  logic                        out_valid,
	input  logic                        out_ready,
	output int                          tests_done,
	output int                          tests_passed,
	output int                          tests_failed,
	output int                          other_errors
);

	import power_meter_pkg::*;

	localparam int BLOCK   = 1 << `BLOCK_LOG2; // Samples per block.
	localparam int LATENCY = 4;                 // Last sample edge to out_valid rise.

	string  test_name[$];
	int     test_stall[$];
	int     test_first[$]; // Index of the first expected sum of each test.
	int     test_count[$];
	longint exp_sum[$];
	int     last_cycle[$]; // Edge of each block's last input transfer.
	int     cycle;
	int     in_count;
	int     first_cycle;   // Edge where the pending output was first seen.
	int     idx;           // Block index within the current test.
	bit     pending;
	bit     test_bad;
	bit     in_reset;

	initial
	begin
		int     fd;
		string  line;
		string  tag;
		string  name;
		int     stall;
		longint value;
		tests_done   = 0;
		tests_passed = 0;
		tests_failed = 0;
		other_errors = 0;
		cycle        = 0;
		in_count     = 0;
		idx          = 0;
		pending      = 0;
		test_bad     = 0;
		in_reset     = 0;
		fd = $fopen("verification/power_meter_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Checker could not open the test file.");
			other_errors = 1;
		end
		else
		begin
			while ($fgets(line, fd))
			begin
				if ($sscanf(line, "%s", tag) < 1)
					continue; // Blank line.
				if (tag == "T")
				begin
					void'($sscanf(line, "%s %s %d", tag, name, stall));
					test_name.push_back(name);
					test_stall.push_back(stall);
					test_first.push_back(exp_sum.size());
					test_count.push_back(0);
				end
				else if (tag == "E")
				begin
					void'($sscanf(line, "%s %d", tag, value));
					exp_sum.push_back(value);
					test_count[test_count.size()-1]++; // Belongs to the latest test.
				end
			end
			$fclose(fd);
		end
	end

	// Reset state, checked during reset and on the first edge after it.
	always @(posedge clock)
	begin
		if (in_reset)
		begin
			if (out_valid !== 1'b0 || in_ready !== 1'b1)
			begin
				$display("Reset state wrong at %0t: out_valid %b, in_ready %b.",
					$time, out_valid, in_ready);
				other_errors++;
			end
		end
		in_reset <= !resetn;
	end

	always @(posedge clock)
	begin
		if (resetn)
		begin
			cycle++;
			if (in_valid && in_ready)
			begin
				in_count++;
				if (in_count % BLOCK == 0)
					last_cycle.push_back(cycle); // Block closed on this edge.
			end
			if (out_valid && !pending)
			begin
				first_cycle = cycle; // Valid rose just before this edge.
				pending     = 1;
			end
			if (out_valid && out_ready)
				take_output();
		end
	end

	task automatic take_output();
		int in_cycle;
		in_cycle = (last_cycle.size() > 0) ? last_cycle.pop_front() : -1;
		pending  = 0;
		if (tests_done >= test_name.size())
		begin
			$display("Extra output %0d at %0t after the last test.", out_data.value, $time);
			other_errors++;
			return;
		end
		if (in_cycle < 0)
		begin
			$display("Output at %0t arrived before its block was sent.", $time);
			test_bad = 1;
		end
		else if (test_stall[tests_done] == 0 && first_cycle - in_cycle - 1 != LATENCY)
		begin
			$display("Bad latency in test %s block %0d: %0d cycles instead of %0d.",
				test_name[tests_done], idx, first_cycle - in_cycle - 1, LATENCY);
			test_bad = 1;
		end
		if (out_data.value !== exp_sum[test_first[tests_done] + idx])
		begin
			$display("[ERROR] %0t: test %s block %0d expected %0d received %0d", $time,
				test_name[tests_done], idx, exp_sum[test_first[tests_done] + idx],
				out_data.value);
			test_bad = 1;
		end
		idx++;
		if (idx == test_count[tests_done])
		begin
			$display("Test %s: %s, %0d blocks.", test_name[tests_done],
				test_bad ? "failed" : "passed", idx);
			if (test_bad)
				tests_failed++;
			else
				tests_passed++;
			idx        = 0;
			test_bad   = 0;
			tests_done = tests_done + 1; // Lets the stimulus start the next test.
		end
	endtask

endmodule

/* verification/power_meter_tb.sv */
// Testbench top of the power meter: clock, reset, file-driven stimulus, random stalls, watchdog.
`timescale 1ns/1ps
`include "power_meter_cfg.svh"

module power_meter_tb;

	import power_meter_pkg::*;

	logic       clock;
	logic       resetn;
	iq_sample_t in_data;
	logic       in_valid;
	logic       in_ready;
	block_sum_t out_data;
	logic       out_valid;
	logic       out_ready;

	int     tests_done;
	int     tests_passed;
	int     tests_failed;
	int     other_errors;
	integer seed;
	int     stall;       // Stall percent of the running test.
	int     limit;       // Watchdog length in cycles.
	bit     limit_ready;
	string  test_name[$];
	int     test_stall[$];
	int     s_test[$];   // Test index of each sample.
	int     s_i[$];
	int     s_q[$];
	int     s_gap[$];

	power_meter power_meter_inst (
		.clock    (clock),
		.resetn   (resetn),
		.in_data  (in_data),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	power_meter_checker checker_inst (
		.clock       (clock),
		.resetn      (resetn),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.tests_done  (tests_done),
		.tests_passed(tests_passed),
		.tests_failed(tests_failed),
		.other_errors(other_errors)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Random back-pressure, redrawn every cycle.
	always @(posedge clock)
	begin
		if (stall == 0)
			out_ready <= #1 1'b1;
		else
			out_ready <= #1 ($unsigned($random(seed)) % 100) >= stall;
	end

	task automatic read_tests();
		int    fd;
		int    i;
		int    q;
		int    gap;
		int    st;
		string line;
		string tag;
		string name;
		fd = $fopen("verification/power_meter_tests.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd))
		begin
			if ($sscanf(line, "%s", tag) < 1)
				continue;
			if (tag == "T")
			begin
				void'($sscanf(line, "%s %s %d", tag, name, st));
				test_name.push_back(name);
				test_stall.push_back(st);
			end
			else if (tag == "S")
			begin
				void'($sscanf(line, "%s %d %d %d", tag, i, q, gap));
				s_test.push_back(test_name.size() - 1);
				s_i.push_back(i);
				s_q.push_back(q);
				s_gap.push_back(gap);
			end
		end
		$fclose(fd);
	endtask

	// Idles for the gap, then holds the sample until in_ready takes it.
	task automatic send_sample(input int i, input int q, input int gap);
		bit taken;
		repeat (gap)
		begin
			@(posedge clock);
			#1;
		end
		in_data.i = i;
		in_data.q = q;
		in_valid  = 1'b1;
		do
		begin
			taken = in_ready; // Stable between the drive point and the edge.
			@(posedge clock);
			#1;
		end
		while (!taken);
		in_valid = 1'b0;
	endtask

	initial
	begin
		int k;
		int t;
		seed        = 32'h6c4d16d7;
		stall       = 0;
		in_data     = '0;
		in_valid    = 1'b0;
		out_ready   = 1'b1;
		resetn      = 1'b0;
		limit_ready = 0;
		read_tests();
		if (test_name.size() == 0)
			$display("No tests could be read from the test file.");
		limit = 200;
		for (k = 0; k < s_i.size(); k++)
			limit += (1 + s_gap[k]) * 20;
		limit_ready = 1;
		repeat (8) @(posedge clock);
		#1;
		resetn = 1'b1;
		k = 0;
		for (t = 0; t < test_name.size(); t++)
		begin
			stall = test_stall[t];
			while (k < s_i.size() && s_test[k] == t)
			begin
				send_sample(s_i[k], s_q[k], s_gap[k]);
				k++;
			end
			while (tests_done <= t) // All of this test's sums are in.
			begin
				@(posedge clock);
				#1;
			end
		end
		stall = 0;
		repeat (20) @(posedge clock); // Room for any extra output to show up.
		$display("Tests passed %0d, failed %0d, other errors %0d.", tests_passed,
			tests_failed, other_errors);
		if (test_name.size() > 0 && tests_failed == 0 && other_errors == 0
			&& tests_done == test_name.size())
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		wait (limit_ready);
		repeat (limit) @(posedge clock);
		$display("Timeout after %0d cycles: only %0d of %0d tests got all their block sums.",
			limit, tests_done, test_name.size());
		$display("** FAIL **");
		$finish;
	end

endmodule

/* verification/power_meter_tests.txt */
# Columns: T <test name> <stall percent> | S <i> <q> <gap cycles before the sample>
# Columns: E <expected block sum, decimal>; every test has whole blocks of 4 samples.
T basic 0
S 1 0 0
S 0 1 0
S 1 1 0
S 2 2 0
E 12
S 3 4 0
S -3 -4 0
S 10 0 0
S 0 -10 0
E 250
T extremes 0
S -2048 -2048 0
S -2048 -2048 0
S -2048 -2048 0
S -2048 -2048 0
E 33554432
S 2047 2047 0
S 2047 2047 0
S 2047 2047 0
S 2047 2047 0
E 33521672
S -2048 2047 0
S 2047 -2048 0
S -2048 2047 0
S 2047 -2048 0
E 33538052
T latency 0
S 5 5 0
S 6 -7 0
S -8 1 0
S 0 0 0
E 200
S 100 -100 0
S -100 100 0
S 100 100 0
S -100 -100 0
E 80000
T gapped 0
S 1 2 3
S 3 1 0
S -2 -2 5
S 4 0 1
E 39
S 7 7 2
S -1 0 7
S 0 3 0
S 5 -5 4
E 158
T stall30 30
S 1000 -1000 0
S -1500 500 0
S 123 456 0
S -7 9 0
E 4723195
S 2047 -2048 0
S 0 -2048 0
S -1 -1 0
S 512 512 0
E 13103107
S 11 13 0
S -20 30 0
S 64 -64 0
S 255 0 0
E 74807
T stall70 70
S 300 400 0
S -300 -400 0
S 1 1 0
S 2 3 0
E 500015
S -2048 0 0
S 0 2047 0
S 100 0 0
S 0 -100 0
E 8404513
S 9 -9 2
S -9 9 0
S 9 9 1
S -9 -9 3
E 648
S 50 60 0
S -70 80 0
S 15 -25 0
S -33 44 0
E 21275

/* files.f */
+incdir+source
source/power_meter_pkg.sv
source/axis_register.sv
source/power_square.sv
source/block_accumulate.sv
source/power_meter.sv
verification/power_meter_checker.sv
verification/power_meter_tb.sv

/* Bender.yml */
package:
  name: power_meter

sources:
  - include_dirs:
      - source
    files:
      - source/power_meter_pkg.sv
      - source/axis_register.sv
      - source/power_square.sv
      - source/block_accumulate.sv
      - source/power_meter.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/power_meter_checker.sv
      - verification/power_meter_tb.sv
